/* Bender.yml */
package:
  name: lab4_controller

sources:
  # package first, then the blocks, then the top level
  - logic/lab4_pkg.sv
  - logic/lab4_regs.sv
  - logic/lab4_serial_writer.sv
  - logic/lab4_ramp_timer.sv
  - logic/lab4_force_trigger.sv
  - logic/lab4_controller.sv
  - target: test
    files:
      - verif/lab4_controller_tb.sv

/* filelist.f */
logic/lab4_pkg.sv
logic/lab4_regs.sv
logic/lab4_serial_writer.sv
logic/lab4_ramp_timer.sv
logic/lab4_force_trigger.sv
logic/lab4_controller.sv
verif/lab4_controller_tb.sv

/* logic/lab4_controller.sv */
module lab4_controller #(
	parameter int NUM_LABS = 4,
	parameter int NUM_REGCLR = 1
) (
	input  logic                                clk_i,
	input  logic                                reset_i,

	input  logic                                bus_stb_i,
	input  logic                                bus_we_i,
	input  logic [lab4_pkg::BUS_ADR_WIDTH-1:0]  bus_adr_i,
	input  logic [lab4_pkg::BUS_DAT_WIDTH-1:0]  bus_dat_i,
	output logic [lab4_pkg::BUS_DAT_WIDTH-1:0]  bus_dat_o,
	output logic                                bus_ack_o,

	input  logic                                complete_i,

	output logic [NUM_LABS-1:0]                 sin_o,
	output logic                                sclk_o,
	output logic [NUM_LABS-1:0]                 pclk_o,
	output logic                                ramp_o,
	output logic                                wclk_en_o,
	output logic                                readout_o,
	output logic                                event_done_o,
	output logic [NUM_REGCLR-1:0]               regclear_o,
	output logic                                test_pattern_o
);
	import lab4_pkg::*;

	localparam int SEL_WIDTH = (NUM_LABS == (1 << $clog2(NUM_LABS))) ?
		($clog2(NUM_LABS) + 1) : $clog2(NUM_LABS);

	////////////////////////////////////////////////////////////
	// settings and strobes out of the register bank
	////////////////////////////////////////////////////////////

	prescale_t shift_prescale;
	count16_t ramp_to_wilk;
	count16_t wclk_stop;
	logic [LAB4_REG_WIDTH-1:0] serial_value;
	logic [SEL_WIDTH-1:0] serial_select;
	logic [7:0] force_count;
	logic serial_go;
	logic ramp_go;
	logic force_go;
	logic wilk_reset;

	// status back into the register bank
	logic serial_busy;
	logic ramp_busy;
	logic forcing;
	logic readout_outstanding;

	lab4_regs #(
		.NUM_LABS(NUM_LABS),
		.NUM_REGCLR(NUM_REGCLR)
	) u_regs (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.bus_stb_i(bus_stb_i),
		.bus_we_i(bus_we_i),
		.bus_adr_i(bus_adr_i),
		.bus_dat_i(bus_dat_i),
		.bus_dat_o(bus_dat_o),
		.bus_ack_o(bus_ack_o),
		.serial_busy_i(serial_busy),
		.ramp_busy_i(ramp_busy),
		.forcing_i(forcing),
		.readout_outstanding_i(readout_outstanding),
		.shift_prescale_o(shift_prescale),
		.ramp_to_wilk_o(ramp_to_wilk),
		.wclk_stop_o(wclk_stop),
		.serial_value_o(serial_value),
		.serial_select_o(serial_select),
		.force_count_o(force_count),
		.serial_go_o(serial_go),
		.ramp_go_o(ramp_go),
		.force_go_o(force_go),
		.wilk_reset_o(wilk_reset),
		.regclear_o(regclear_o),
		.test_pattern_o(test_pattern_o)
	);

	////////////////////////////////////////////////////////////
	// chip side engines
	////////////////////////////////////////////////////////////

	lab4_serial_writer #(
		.NUM_LABS(NUM_LABS)
	) u_serial (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.go_i(serial_go),
		.value_i(serial_value),
		.select_i(serial_select),
		.prescale_i(shift_prescale),
		.busy_o(serial_busy),
		.sin_o(sin_o),
		.sclk_o(sclk_o),
		.pclk_o(pclk_o)
	);

	lab4_ramp_timer u_ramp (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.go_i(ramp_go),
		.abort_i(wilk_reset),
		.ramp_to_wilk_i(ramp_to_wilk),
		.wclk_stop_i(wclk_stop),
		.busy_o(ramp_busy),
		.ramp_o(ramp_o),
		.wclk_en_o(wclk_en_o)
	);

	lab4_force_trigger u_force (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.go_i(force_go),
		.count_i(force_count),
		.complete_i(complete_i),
		.readout_o(readout_o),
		.forcing_o(forcing),
		.outstanding_o(readout_outstanding),
		.event_done_o(event_done_o)
	);

endmodule

/* logic/lab4_force_trigger.sv */
module lab4_force_trigger (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic        go_i,
	input  logic [7:0]  count_i,
	input  logic        complete_i,
	output logic        readout_o,
	output logic        forcing_o,
	output logic        outstanding_o,
	output logic        event_done_o
);
	// completions so far in this sequence
	logic [7:0] done_cnt;
	// readouts per force, minus one, held for the sequence
	logic [7:0] target;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			readout_o <= 1'b0;
			forcing_o <= 1'b0;
			outstanding_o <= 1'b0;
			event_done_o <= 1'b0;
			done_cnt <= '0;
			target <= '0;
		end else begin
			readout_o <= 1'b0;
			event_done_o <= complete_i;
			if (go_i && !forcing_o) begin
				forcing_o <= 1'b1;
				readout_o <= 1'b1;
				outstanding_o <= 1'b1;
				done_cnt <= '0;
				target <= count_i;
			end else if (complete_i) begin
				outstanding_o <= 1'b0;
				if (forcing_o) begin
					if (done_cnt == target) begin
						forcing_o <= 1'b0;
					end else begin
						// next request only once the last one came back
						readout_o <= 1'b1;
						outstanding_o <= 1'b1;
						done_cnt <= done_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

/* logic/lab4_pkg.sv */
package lab4_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// one chip configuration word
	localparam int LAB4_REG_WIDTH = 24;

	// register bus, word addressed
	localparam int BUS_ADR_WIDTH = 5;
	localparam int BUS_DAT_WIDTH = 32;

	// common setting types
	typedef logic [15:0] count16_t;
	typedef logic [7:0] prescale_t;

	////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////

	localparam logic [BUS_ADR_WIDTH-1:0] ADR_CONTROL = 5'd0;
	localparam logic [BUS_ADR_WIDTH-1:0] ADR_SHIFT_PRESCALE = 5'd1;
	localparam logic [BUS_ADR_WIDTH-1:0] ADR_RAMP_TO_WILK = 5'd3;
	localparam logic [BUS_ADR_WIDTH-1:0] ADR_WCLK_STOP = 5'd4;
	localparam logic [BUS_ADR_WIDTH-1:0] ADR_RAMP_CMD = 5'd5;
	localparam logic [BUS_ADR_WIDTH-1:0] ADR_SERIAL = 5'd6;
	localparam logic [BUS_ADR_WIDTH-1:0] ADR_TRIGGER = 5'd21;
	localparam logic [BUS_ADR_WIDTH-1:0] ADR_READOUT = 5'd22;

	////////////////////////////////////////////////////////////
	// reset values of the settings
	////////////////////////////////////////////////////////////

	// serial clock runs at clk/4 out of reset
	localparam prescale_t SHIFT_PRESCALE_DEFAULT = 8'd1;

	// wilkinson clock starts with the ramp
	localparam count16_t RAMP_TO_WILK_DEFAULT = 16'd0;

	// full 10-bit conversion
	localparam count16_t WCLK_STOP_DEFAULT = 16'd1024;

endpackage

/* logic/lab4_ramp_timer.sv */
module lab4_ramp_timer (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                go_i,
	input  logic                abort_i,
	input  lab4_pkg::count16_t  ramp_to_wilk_i,
	input  lab4_pkg::count16_t  wclk_stop_i,
	output logic                busy_o,
	output logic                ramp_o,
	output logic                wclk_en_o
);
	import lab4_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_RAMP,
		S_WILK
	} state_t;

	state_t state;
	count16_t cnt;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= S_IDLE;
			cnt <= '0;
		end else if (abort_i) begin
			// wilk reset kills the conversion right away
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (go_i) begin
						if (ramp_to_wilk_i == '0) begin
							state <= S_WILK;
							cnt <= wclk_stop_i;
						end else begin
							state <= S_RAMP;
							cnt <= ramp_to_wilk_i;
						end
					end
				end
				// ramp alone until the delay runs out
				S_RAMP: begin
					if (cnt <= 16'd1) begin
						state <= S_WILK;
						cnt <= wclk_stop_i;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				S_WILK: begin
					if (cnt <= 16'd1) begin
						state <= S_IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ramp keeps running through the wilkinson count
	assign ramp_o = (state != S_IDLE);
	assign wclk_en_o = (state == S_WILK);
	assign busy_o = (state != S_IDLE);

endmodule

/* logic/lab4_regs.sv */
module lab4_regs #(
	parameter int NUM_LABS = 4,
	parameter int NUM_REGCLR = 1,
	// select always keeps the all-ones code free for "every chip"
	localparam int SEL_WIDTH = (NUM_LABS == (1 << $clog2(NUM_LABS))) ?
		($clog2(NUM_LABS) + 1) : $clog2(NUM_LABS)
) (
	input  logic                                 clk_i,
	input  logic                                 reset_i,

	input  logic                                 bus_stb_i,
	input  logic                                 bus_we_i,
	input  logic [lab4_pkg::BUS_ADR_WIDTH-1:0]   bus_adr_i,
	input  logic [lab4_pkg::BUS_DAT_WIDTH-1:0]   bus_dat_i,
	output logic [lab4_pkg::BUS_DAT_WIDTH-1:0]   bus_dat_o,
	output logic                                 bus_ack_o,

	input  logic                                 serial_busy_i,
	input  logic                                 ramp_busy_i,
	input  logic                                 forcing_i,
	input  logic                                 readout_outstanding_i,

	output lab4_pkg::prescale_t                  shift_prescale_o,
	output lab4_pkg::count16_t                   ramp_to_wilk_o,
	output lab4_pkg::count16_t                   wclk_stop_o,
	output logic [lab4_pkg::LAB4_REG_WIDTH-1:0]  serial_value_o,
	output logic [SEL_WIDTH-1:0]                 serial_select_o,
	output logic [7:0]                           force_count_o,

	output logic                                 serial_go_o,
	output logic                                 ramp_go_o,
	output logic                                 force_go_o,
	output logic                                 wilk_reset_o,
	output logic [NUM_REGCLR-1:0]                regclear_o,
	output logic                                 test_pattern_o
);
	import lab4_pkg::*;

	logic bus_wr;
	logic [BUS_DAT_WIDTH-1:0] rd_data;

	assign bus_wr = bus_stb_i && bus_we_i;

	////////////////////////////////////////////////////////////
	// settings
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			test_pattern_o <= 1'b0;
			regclear_o <= '0;
			shift_prescale_o <= SHIFT_PRESCALE_DEFAULT;
			ramp_to_wilk_o <= RAMP_TO_WILK_DEFAULT;
			wclk_stop_o <= WCLK_STOP_DEFAULT;
			serial_value_o <= '0;
			serial_select_o <= '0;
			force_count_o <= '0;
		end else if (bus_wr) begin
			case (bus_adr_i)
				ADR_CONTROL: begin
					test_pattern_o <= bus_dat_i[15];
					regclear_o <= bus_dat_i[16 +: NUM_REGCLR];
				end
				ADR_SHIFT_PRESCALE: shift_prescale_o <= bus_dat_i[7:0];
				ADR_RAMP_TO_WILK: ramp_to_wilk_o <= bus_dat_i[15:0];
				ADR_WCLK_STOP: wclk_stop_o <= bus_dat_i[15:0];
				ADR_SERIAL: begin
					serial_value_o <= bus_dat_i[LAB4_REG_WIDTH-1:0];
					serial_select_o <= bus_dat_i[24 +: SEL_WIDTH];
				end
				// bits 15:8 hold readouts per force, minus one
				ADR_TRIGGER: force_count_o <= bus_dat_i[15:8];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// command strobes, one cycle after the write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			serial_go_o <= 1'b0;
			ramp_go_o <= 1'b0;
			force_go_o <= 1'b0;
			wilk_reset_o <= 1'b0;
		end else begin
			serial_go_o <= bus_wr && (bus_adr_i == ADR_SERIAL) && bus_dat_i[31];
			ramp_go_o <= bus_wr && (bus_adr_i == ADR_RAMP_CMD) && bus_dat_i[0];
			force_go_o <= bus_wr && (bus_adr_i == ADR_TRIGGER) && bus_dat_i[1];
			wilk_reset_o <= bus_wr && (bus_adr_i == ADR_CONTROL) && bus_dat_i[8];
		end
	end

	////////////////////////////////////////////////////////////
	// read data and acknowledge
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_data = '0;
		case (bus_adr_i)
			ADR_CONTROL: begin
				rd_data[15] = test_pattern_o;
				rd_data[16 +: NUM_REGCLR] = regclear_o;
			end
			ADR_SHIFT_PRESCALE: rd_data[7:0] = shift_prescale_o;
			ADR_RAMP_TO_WILK: rd_data[15:0] = ramp_to_wilk_o;
			ADR_WCLK_STOP: rd_data[15:0] = wclk_stop_o;
			ADR_RAMP_CMD: rd_data[0] = ramp_busy_i;
			ADR_SERIAL: begin
				rd_data[LAB4_REG_WIDTH-1:0] = serial_value_o;
				rd_data[24 +: SEL_WIDTH] = serial_select_o;
				rd_data[31] = serial_busy_i;
			end
			ADR_TRIGGER: begin
				rd_data[15:8] = force_count_o;
				rd_data[5] = forcing_i;
			end
			ADR_READOUT: begin
				rd_data[0] = readout_outstanding_i;
				rd_data[5] = forcing_i;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (bus_stb_i) begin
			bus_dat_o <= rd_data;
		end
	end

	// no wait states, every strobe answers next cycle
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			bus_ack_o <= 1'b0;
		end else begin
			bus_ack_o <= bus_stb_i;
		end
	end

endmodule

/* logic/lab4_serial_writer.sv */
module lab4_serial_writer #(
	parameter int NUM_LABS = 4,
	localparam int SEL_WIDTH = (NUM_LABS == (1 << $clog2(NUM_LABS))) ?
		($clog2(NUM_LABS) + 1) : $clog2(NUM_LABS)
) (
	input  logic                                 clk_i,
	input  logic                                 reset_i,
	input  logic                                 go_i,
	input  logic [lab4_pkg::LAB4_REG_WIDTH-1:0]  value_i,
	input  logic [SEL_WIDTH-1:0]                 select_i,
	input  lab4_pkg::prescale_t                  prescale_i,
	output logic                                 busy_o,
	output logic [NUM_LABS-1:0]                  sin_o,
	output logic                                 sclk_o,
	output logic [NUM_LABS-1:0]                  pclk_o
);
	import lab4_pkg::*;

	localparam int BIT_CNT_WIDTH = $clog2(LAB4_REG_WIDTH);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOW,
		S_HIGH,
		S_LATCH,
		S_DONE
	} state_t;

	state_t state;
	prescale_t pre_cnt;
	logic pre_done;
	logic [BIT_CNT_WIDTH-1:0] bit_cnt;
	logic [LAB4_REG_WIDTH-1:0] shift_q;
	logic [NUM_LABS-1:0] sel_mask;
	logic [NUM_LABS-1:0] mask_q;

	// all ones selects every chip, otherwise one-hot
	always_comb begin
		sel_mask = '0;
		if (&select_i) begin
			sel_mask = '1;
		end else begin
			for (int i = 0; i < NUM_LABS; i++) begin
				sel_mask[i] = (select_i == SEL_WIDTH'(i));
			end
		end
	end

	assign pre_done = (pre_cnt == prescale_i);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= S_IDLE;
			pre_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (go_i) begin
						state <= S_LOW;
						pre_cnt <= '0;
						bit_cnt <= BIT_CNT_WIDTH'(LAB4_REG_WIDTH - 1);
					end
				end
				// data settles while sclk is low
				S_LOW: begin
					pre_cnt <= pre_done ? '0 : pre_cnt + 1'b1;
					if (pre_done) begin
						state <= S_HIGH;
					end
				end
				S_HIGH: begin
					pre_cnt <= pre_done ? '0 : pre_cnt + 1'b1;
					if (pre_done) begin
						if (bit_cnt == '0) begin
							state <= S_LATCH;
						end else begin
							bit_cnt <= bit_cnt - 1'b1;
							state <= S_LOW;
						end
					end
				end
				// pclk loads the shifted word into the chip
				S_LATCH: begin
					pre_cnt <= pre_done ? '0 : pre_cnt + 1'b1;
					if (pre_done) begin
						state <= S_DONE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// word and chip mask held for the whole write
	always_ff @(posedge clk_i) begin
		if (state == S_IDLE && go_i) begin
			shift_q <= value_i;
			mask_q <= sel_mask;
		end else if (state == S_HIGH && pre_done) begin
			shift_q <= {shift_q[LAB4_REG_WIDTH-2:0], 1'b0};
		end
	end

	assign busy_o = (state != S_IDLE);
	assign sclk_o = (state == S_HIGH);
	assign sin_o = (state == S_LOW || state == S_HIGH) ?
		(mask_q & {NUM_LABS{shift_q[LAB4_REG_WIDTH-1]}}) : '0;
	assign pclk_o = (state == S_LATCH) ? mask_q : '0;

endmodule

/* verif/lab4_controller_tb.sv */
module lab4_controller_tb;
	import lab4_pkg::*;

	localparam int NUM_LABS = 4;
	localparam int NUM_REGCLR = 1;
	localparam int CLK_PERIOD = 10;
	localparam int POLL_LIMIT = 1000;
	// longest row is a serial write at prescale 3, about 210 cycles
	localparam int OP_BOUND = 250;
	localparam int MARGIN = 200;

	// row kinds of the stimulus table
	localparam int OP_WRITE = 0;
	localparam int OP_READ = 1;
	localparam int OP_SERIAL = 2;
	localparam int OP_RAMP = 3;
	localparam int OP_ABORT = 4;
	localparam int OP_FORCE = 5;

	logic clk_i;
	logic reset_i;
	logic bus_stb_i;
	logic bus_we_i;
	logic [BUS_ADR_WIDTH-1:0] bus_adr_i;
	logic [BUS_DAT_WIDTH-1:0] bus_dat_i;
	logic [BUS_DAT_WIDTH-1:0] bus_dat_o;
	logic bus_ack_o;
	logic complete_i;
	logic [NUM_LABS-1:0] sin_o;
	logic sclk_o;
	logic [NUM_LABS-1:0] pclk_o;
	logic ramp_o;
	logic wclk_en_o;
	logic readout_o;
	logic event_done_o;
	logic [NUM_REGCLR-1:0] regclear_o;
	logic test_pattern_o;

	// stimulus table, one entry per row in each queue
	int kind_q[$];
	logic [BUS_ADR_WIDTH-1:0] adr_q[$];
	logic [BUS_DAT_WIDTH-1:0] dat_q[$];
	logic [BUS_DAT_WIDTH-1:0] exp_q[$];
	logic rows_ready = 1'b0;

	integer seed = 17310;
	int errors = 0;
	int checks = 0;
	logic [7:0] cur_prescale = 8'd1;

	// observed activity
	logic stb_q = 1'b0;
	logic complete_q = 1'b0;
	int readouts = 0;
	int completions = 0;
	int event_dones = 0;
	logic [LAB4_REG_WIDTH-1:0] captured [NUM_LABS];
	int pclk_pulses [NUM_LABS];
	int sclk_rises = 0;
	int high_run = 0;
	int high_min = 0;
	int high_max = 0;
	logic sclk_q = 1'b0;
	logic [NUM_LABS-1:0] pclk_q = '0;
	int ramp_cycles = 0;
	int wilk_cycles = 0;
	int joint_falls = 0;
	logic split_fall = 1'b0;
	logic ramp_q = 1'b0;
	logic wclk_q = 1'b0;

	lab4_controller #(
		.NUM_LABS(NUM_LABS),
		.NUM_REGCLR(NUM_REGCLR)
	) UUT (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.bus_stb_i(bus_stb_i),
		.bus_we_i(bus_we_i),
		.bus_adr_i(bus_adr_i),
		.bus_dat_i(bus_dat_i),
		.bus_dat_o(bus_dat_o),
		.bus_ack_o(bus_ack_o),
		.complete_i(complete_i),
		.sin_o(sin_o),
		.sclk_o(sclk_o),
		.pclk_o(pclk_o),
		.ramp_o(ramp_o),
		.wclk_en_o(wclk_en_o),
		.readout_o(readout_o),
		.event_done_o(event_done_o),
		.regclear_o(regclear_o),
		.test_pattern_o(test_pattern_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// one strobe, called on a falling edge, returns on the acknowledge cycle
	task automatic bus_access(input logic we, input logic [BUS_ADR_WIDTH-1:0] adr,
			input logic [BUS_DAT_WIDTH-1:0] dat, output logic [BUS_DAT_WIDTH-1:0] rd);
		bus_stb_i = 1'b1;
		bus_we_i = we;
		bus_adr_i = adr;
		bus_dat_i = dat;
		@(negedge clk_i);
		bus_stb_i = 1'b0;
		bus_we_i = 1'b0;
		rd = bus_dat_o;
	endtask

	task automatic register_write(input logic [BUS_ADR_WIDTH-1:0] adr,
			input logic [BUS_DAT_WIDTH-1:0] dat);
		logic [BUS_DAT_WIDTH-1:0] rd;
		bus_access(1'b1, adr, dat, rd);
		if (adr == ADR_SHIFT_PRESCALE) begin
			cur_prescale = dat[7:0];
		end
		if (adr == ADR_CONTROL) begin
			check_value("test_pattern_o", test_pattern_o, dat[15]);
			check_value("regclear_o", regclear_o, dat[16]);
		end
	endtask

	// read a status bit until it reaches the wanted level
	task automatic poll_status(input logic [BUS_ADR_WIDTH-1:0] adr, input int bit_idx,
			input logic level, input string what);
		logic [BUS_DAT_WIDTH-1:0] rd;
		int polls;
		polls = 0;
		bus_access(1'b0, adr, '0, rd);
		while (rd[bit_idx] !== level && polls < POLL_LIMIT) begin
			bus_access(1'b0, adr, '0, rd);
			polls++;
		end
		checks++;
		assert (rd[bit_idx] === level) else begin
			$display("%s did not go to %0d within %0d reads", what, level, POLL_LIMIT);
			errors++;
		end
	endtask

	task automatic serial_program(input logic [BUS_DAT_WIDTH-1:0] word);
		logic [BUS_DAT_WIDTH-1:0] rd;
		logic [2:0] sel;
		logic [NUM_LABS-1:0] mask;
		sel = word[26:24];
		mask = (sel == 3'b111) ? '1 : (NUM_LABS'(1) << sel);
		sclk_rises = 0;
		high_run = 0;
		high_min = 1000;
		high_max = 0;
		for (int i = 0; i < NUM_LABS; i++) begin
			captured[i] = '0;
			pclk_pulses[i] = 0;
		end
		bus_access(1'b1, ADR_SERIAL, word | 32'h8000_0000, rd);
		poll_status(ADR_SERIAL, 31, 1'b1, "serial busy");
		poll_status(ADR_SERIAL, 31, 1'b0, "serial busy");
		for (int i = 0; i < NUM_LABS; i++) begin
			check_value($sformatf("sin_o[%0d] word", i), captured[i],
				mask[i] ? word[23:0] : 24'h0);
			check_value($sformatf("pclk_o[%0d] pulses", i), pclk_pulses[i], mask[i]);
		end
		check_value("sclk_o rising edges", sclk_rises, LAB4_REG_WIDTH);
		check_value("sclk_o shortest high phase", high_min, int'(cur_prescale) + 1);
		check_value("sclk_o longest high phase", high_max, int'(cur_prescale) + 1);
	endtask

	// setting holds the stop count above the ramp delay
	task automatic ramp_convert(input logic [BUS_DAT_WIDTH-1:0] setting);
		logic [BUS_DAT_WIDTH-1:0] rd;
		register_write(ADR_RAMP_TO_WILK, {16'h0, setting[15:0]});
		register_write(ADR_WCLK_STOP, {16'h0, setting[31:16]});
		ramp_cycles = 0;
		wilk_cycles = 0;
		joint_falls = 0;
		split_fall = 1'b0;
		bus_access(1'b1, ADR_RAMP_CMD, 32'h1, rd);
		poll_status(ADR_RAMP_CMD, 0, 1'b1, "ramp busy");
		poll_status(ADR_RAMP_CMD, 0, 1'b0, "ramp busy");
		check_value("ramp_o cycles before wclk_en_o", ramp_cycles, setting[15:0]);
		check_value("wclk_en_o cycles", wilk_cycles, setting[31:16]);
		checks++;
		assert (joint_falls == 1 && !split_fall) else begin
			$display("ramp_o and wclk_en_o did not fall together");
			errors++;
		end
	endtask

	// short delay so the abort lands while the wilkinson clock runs
	task automatic ramp_abort(input logic [BUS_DAT_WIDTH-1:0] setting);
		logic [BUS_DAT_WIDTH-1:0] rd;
		register_write(ADR_RAMP_TO_WILK, {16'h0, setting[15:0]});
		register_write(ADR_WCLK_STOP, {16'h0, setting[31:16]});
		bus_access(1'b1, ADR_RAMP_CMD, 32'h1, rd);
		poll_status(ADR_RAMP_CMD, 0, 1'b1, "ramp busy");
		repeat (3) @(negedge clk_i);
		check_value("ramp_o", ramp_o, 1'b1);
		check_value("wclk_en_o", wclk_en_o, 1'b1);
		// wilk reset lands one cycle after the control write
		register_write(ADR_CONTROL, 32'h0000_0100);
		@(negedge clk_i);
		check_value("ramp_o", ramp_o, 1'b0);
		check_value("wclk_en_o", wclk_en_o, 1'b0);
		poll_status(ADR_RAMP_CMD, 0, 1'b0, "ramp busy");
	endtask

	task automatic force_sequence(input logic [7:0] count);
		logic [BUS_DAT_WIDTH-1:0] rd;
		int ro0;
		int cmp0;
		int evd0;
		ro0 = readouts;
		cmp0 = completions;
		evd0 = event_dones;
		bus_access(1'b1, ADR_TRIGGER, {16'h0, count, 8'h02}, rd);
		poll_status(ADR_TRIGGER, 5, 1'b1, "forcing");
		poll_status(ADR_TRIGGER, 5, 1'b0, "forcing");
		check_value("readout_o pulses", readouts - ro0, int'(count) + 1);
		check_value("complete_i pulses", completions - cmp0, int'(count) + 1);
		check_value("event_done_o pulses", event_dones - evd0, int'(count) + 1);
	endtask

	task automatic add_row(input int kind, input logic [BUS_ADR_WIDTH-1:0] adr,
			input logic [BUS_DAT_WIDTH-1:0] dat, input logic [BUS_DAT_WIDTH-1:0] exp);
		kind_q.push_back(kind);
		adr_q.push_back(adr);
		dat_q.push_back(dat);
		exp_q.push_back(exp);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////

	task automatic fill_table();
		// reset values
		add_row(OP_READ, ADR_CONTROL, 32'h0, 32'h0);
		add_row(OP_READ, ADR_SHIFT_PRESCALE, 32'h0, 32'h1);
		add_row(OP_READ, 5'd2, 32'h0, 32'h0);
		add_row(OP_READ, ADR_RAMP_TO_WILK, 32'h0, 32'h0);
		add_row(OP_READ, ADR_WCLK_STOP, 32'h0, 32'h400);
		add_row(OP_READ, ADR_RAMP_CMD, 32'h0, 32'h0);
		add_row(OP_READ, ADR_SERIAL, 32'h0, 32'h0);
		add_row(OP_READ, ADR_TRIGGER, 32'h0, 32'h0);
		add_row(OP_READ, ADR_READOUT, 32'h0, 32'h0);
		add_row(OP_READ, 5'd31, 32'h0, 32'h0);
		// read back, masked to field widths
		add_row(OP_WRITE, ADR_SHIFT_PRESCALE, 32'h1234_56ab, 32'h0);
		add_row(OP_READ, ADR_SHIFT_PRESCALE, 32'h0, 32'h0000_00ab);
		add_row(OP_WRITE, ADR_RAMP_TO_WILK, 32'hdead_beef, 32'h0);
		add_row(OP_READ, ADR_RAMP_TO_WILK, 32'h0, 32'h0000_beef);
		add_row(OP_WRITE, ADR_WCLK_STOP, 32'hffff_0123, 32'h0);
		add_row(OP_READ, ADR_WCLK_STOP, 32'h0, 32'h0000_0123);
		add_row(OP_WRITE, ADR_SERIAL, 32'h7eab_cdef, 32'h0);
		add_row(OP_READ, ADR_SERIAL, 32'h0, 32'h06ab_cdef);
		add_row(OP_WRITE, ADR_TRIGGER, 32'hffff_ff00, 32'h0);
		add_row(OP_READ, ADR_TRIGGER, 32'h0, 32'h0000_ff00);
		add_row(OP_WRITE, ADR_RAMP_CMD, 32'hffff_fffe, 32'h0);
		add_row(OP_READ, ADR_RAMP_CMD, 32'h0, 32'h0);
		add_row(OP_WRITE, 5'd2, 32'hffff_ffff, 32'h0);
		add_row(OP_READ, 5'd2, 32'h0, 32'h0);
		// control outputs
		add_row(OP_WRITE, ADR_CONTROL, 32'hffff_feff, 32'h0);
		add_row(OP_READ, ADR_CONTROL, 32'h0, 32'h0001_8000);
		add_row(OP_WRITE, ADR_CONTROL, 32'h0000_8000, 32'h0);
		add_row(OP_READ, ADR_CONTROL, 32'h0, 32'h0000_8000);
		add_row(OP_WRITE, ADR_CONTROL, 32'h0001_0000, 32'h0);
		add_row(OP_READ, ADR_CONTROL, 32'h0, 32'h0001_0000);
		add_row(OP_WRITE, ADR_CONTROL, 32'h0, 32'h0);
		add_row(OP_READ, ADR_CONTROL, 32'h0, 32'h0);
		// serial writes, select in bits 26:24
		add_row(OP_WRITE, ADR_SHIFT_PRESCALE, 32'h1, 32'h0);
		add_row(OP_SERIAL, ADR_SERIAL, 32'h02a5_c35e, 32'h0);
		add_row(OP_SERIAL, ADR_SERIAL, 32'h0012_3456, 32'h0);
		add_row(OP_WRITE, ADR_SHIFT_PRESCALE, 32'h0, 32'h0);
		add_row(OP_SERIAL, ADR_SERIAL, 32'h07c3_a5f1, 32'h0);
		add_row(OP_WRITE, ADR_SHIFT_PRESCALE, 32'h3, 32'h0);
		add_row(OP_SERIAL, ADR_SERIAL, 32'h075a_5a5a, 32'h0);
		add_row(OP_SERIAL, ADR_SERIAL, 32'h0380_0001, 32'h0);
		add_row(OP_READ, ADR_SERIAL, 32'h0, 32'h0380_0001);
		// ramp rows hold {stop, delay}
		add_row(OP_RAMP, ADR_RAMP_CMD, 32'h000c_0005, 32'h0);
		add_row(OP_RAMP, ADR_RAMP_CMD, 32'h0007_0000, 32'h0);
		add_row(OP_RAMP, ADR_RAMP_CMD, 32'h0001_0003, 32'h0);
		add_row(OP_ABORT, ADR_RAMP_CMD, 32'h001e_0002, 32'h0);
		add_row(OP_READ, ADR_RAMP_CMD, 32'h0, 32'h0);
		// force triggers
		add_row(OP_FORCE, ADR_TRIGGER, 32'd0, 32'h0);
		add_row(OP_FORCE, ADR_TRIGGER, 32'd2, 32'h0);
		add_row(OP_FORCE, ADR_TRIGGER, 32'd5, 32'h0);
		add_row(OP_READ, ADR_TRIGGER, 32'h0, 32'h0000_0500);
		add_row(OP_READ, ADR_READOUT, 32'h0, 32'h0);
	endtask

	////////////////////////////////////////////////////////////
	// monitors and readout responder
	////////////////////////////////////////////////////////////

	always @(posedge clk_i) begin
		stb_q <= bus_stb_i;
		complete_q <= complete_i;
		if (complete_i) begin
			completions <= completions + 1;
		end
	end

	always @(negedge clk_i) begin
		check_value("bus_ack_o", bus_ack_o, stb_q);
		check_value("event_done_o", event_done_o, complete_q);
		if (event_done_o) begin
			event_dones++;
		end
		if (readout_o) begin
			checks++;
			assert (readouts == completions) else begin
				$display("readout_o pulsed while an earlier readout was still outstanding");
				errors++;
			end
			readouts++;
		end
	end

	// serial decoder, SIN taken on each SCLK rise
	always @(negedge clk_i) begin
		if (sclk_o && !sclk_q) begin
			sclk_rises++;
			for (int i = 0; i < NUM_LABS; i++) begin
				captured[i] = {captured[i][LAB4_REG_WIDTH-2:0], sin_o[i]};
			end
		end
		if (sclk_o) begin
			high_run++;
		end else if (sclk_q) begin
			high_min = (high_run < high_min) ? high_run : high_min;
			high_max = (high_run > high_max) ? high_run : high_max;
			high_run = 0;
		end
		for (int i = 0; i < NUM_LABS; i++) begin
			if (pclk_o[i] && !pclk_q[i]) begin
				pclk_pulses[i]++;
			end
		end
		sclk_q = sclk_o;
		pclk_q = pclk_o;
	end

	always @(negedge clk_i) begin
		if (ramp_o && !wclk_en_o) begin
			ramp_cycles++;
		end
		if (wclk_en_o) begin
			wilk_cycles++;
		end
		if (ramp_q && !ramp_o && wclk_q && !wclk_en_o) begin
			joint_falls++;
		end
		if (wclk_q && !wclk_en_o && ramp_o) begin
			split_fall = 1'b1;
		end
		ramp_q = ramp_o;
		wclk_q = wclk_en_o;
	end

	initial begin
		int delay;
		complete_i = 1'b0;
		forever begin
			@(negedge clk_i);
			while (readout_o) begin
				delay = 1 + ($unsigned($random(seed)) % 8);
				repeat (delay) @(negedge clk_i);
				complete_i = 1'b1;
				@(negedge clk_i);
				complete_i = 1'b0;
			end
		end
	end

	initial begin
		int limit;
		wait (rows_ready);
		limit = (kind_q.size() * OP_BOUND + 10 + MARGIN) * CLK_PERIOD;
		#(limit);
		$display("run did not finish within %0d time units, %0d errors", limit, errors);
		$display("Errors found");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [BUS_DAT_WIDTH-1:0] rd;
		reset_i = 1'b1;
		bus_stb_i = 1'b0;
		bus_we_i = 1'b0;
		bus_adr_i = '0;
		bus_dat_i = '0;
		fill_table();
		rows_ready = 1'b1;
		repeat (10) @(negedge clk_i);
		reset_i = 1'b0;
		@(negedge clk_i);
		for (int r = 0; r < kind_q.size(); r++) begin
			case (kind_q[r])
				OP_WRITE: register_write(adr_q[r], dat_q[r]);
				OP_READ: begin
					bus_access(1'b0, adr_q[r], '0, rd);
					check_value($sformatf("bus_dat_o at address %0d", adr_q[r]), rd, exp_q[r]);
				end
				OP_SERIAL: serial_program(dat_q[r]);
				OP_RAMP: ramp_convert(dat_q[r]);
				OP_ABORT: ramp_abort(dat_q[r]);
				OP_FORCE: force_sequence(dat_q[r][7:0]);
				default: ;
			endcase
		end
		repeat (4) @(negedge clk_i);
		$display("%0d rows, %0d checks, %0d errors", kind_q.size(), checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
